/* hw/rv_core_pkg.sv */
package rv_core_pkg;

    localparam int xlen           = 32;
    localparam int reg_addr_bits  = 5;
    localparam int dmem_words     = 16;
    localparam int dmem_addr_bits = 4;

    // Major opcodes of the supported RV32I subset
    localparam logic [6:0] opcode_op     = 7'b0110011;
    localparam logic [6:0] opcode_op_imm = 7'b0010011;
    localparam logic [6:0] opcode_load   = 7'b0000011;
    localparam logic [6:0] opcode_store  = 7'b0100011;
    localparam logic [6:0] opcode_branch = 7'b1100011;

    localparam logic [2:0] funct3_add_sub = 3'b000;
    localparam logic [2:0] funct3_slt     = 3'b010;
    localparam logic [2:0] funct3_xor     = 3'b100;
    localparam logic [2:0] funct3_or      = 3'b110;
    localparam logic [2:0] funct3_and     = 3'b111;
    localparam logic [2:0] funct3_beq     = 3'b000;
    localparam logic [2:0] funct3_bne     = 3'b001;
    localparam logic [6:0] funct7_sub     = 7'b0100000;

    typedef logic [xlen-1:0]          word_t;
    typedef logic [reg_addr_bits-1:0] reg_addr_t;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt
    } alu_op_t;

    typedef enum logic [1:0] {
        fwd_none,
        fwd_mem,
        fwd_wb
    } fwd_sel_t;

    // Instruction formats, most significant field first
    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
    } instr_t;

    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    mem_to_reg;
        logic    alu_src;
        logic    branch;
        alu_op_t alu_op;
    } ctrl_t;

    typedef struct packed {
        logic   valid;
        word_t  pc;
        instr_t instr;
    } if_id_t;

    typedef struct packed {
        logic       valid;
        ctrl_t      ctrl;
        word_t      pc;
        word_t      rs1_data;
        word_t      rs2_data;
        word_t      imm;
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        reg_addr_t  rd;
        logic [2:0] funct3;
    } id_ex_t;

    typedef struct packed {
        logic      valid;
        ctrl_t     ctrl;
        word_t     alu_result;
        word_t     store_data;
        reg_addr_t rd;
    } ex_mem_t;

    typedef struct packed {
        logic      valid;
        logic      reg_write;
        logic      mem_to_reg;
        word_t     alu_result;
        word_t     load_data;
        reg_addr_t rd;
    } mem_wb_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        word_t     data;
    } wb_report_t;

    typedef struct packed {
        logic  valid;
        word_t addr;
        word_t data;
    } store_report_t;

endpackage

/* hw/fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                stall,
    input  logic                branch_taken,
    input  rv_core_pkg::word_t  branch_target,
    output rv_core_pkg::word_t  imem_addr,
    input  rv_core_pkg::instr_t imem_data,
    output rv_core_pkg::if_id_t if_id
);

    rv_core_pkg::word_t pc;
    rv_core_pkg::word_t pc_next;

    // Instruction memory is read combinationally at the current PC
    assign imem_addr = pc;

    // Taken branch wins, then stall, then sequential fetch
    always_comb begin
        if (branch_taken) begin
            pc_next = branch_target;
        end else if (stall) begin
            pc_next = pc;
        end else begin
            pc_next = pc + rv_core_pkg::word_t'(4);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc          <= '0;
            if_id.valid <= 1'b0;
        end else begin
            pc <= pc_next;
            if (branch_taken) begin
                // Wrong-path fetch is dropped
                if_id.valid <= 1'b0;
            end else if (!stall) begin
                if_id.valid <= 1'b1;
                if_id.pc    <= pc;
                if_id.instr <= imem_data;
            end
        end
    end

endmodule

/* hw/register_file.sv */
`timescale 1ns/1ps

module register_file (
    input  logic                   clk,
    input  logic                   arst_n,
    input  rv_core_pkg::reg_addr_t rs1,
    input  rv_core_pkg::reg_addr_t rs2,
    output rv_core_pkg::word_t     rs1_data,
    output rv_core_pkg::word_t     rs2_data,
    input  logic                   wr_en,
    input  rv_core_pkg::reg_addr_t wr_addr,
    input  rv_core_pkg::word_t     wr_data
);

    rv_core_pkg::word_t regs [32];

    // x0 is never written, so it keeps its reset value of zero
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Same-cycle writeback is passed straight to the readers
    assign rs1_data = (wr_en && wr_addr == rs1 && rs1 != '0) ? wr_data : regs[rs1];
    assign rs2_data = (wr_en && wr_addr == rs2 && rs2 != '0) ? wr_data : regs[rs2];

endmodule

/* hw/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage (
    input  logic                   clk,
    input  logic                   arst_n,
    input  rv_core_pkg::if_id_t    if_id,
    input  logic                   stall,
    input  logic                   flush,
    input  logic                   wb_en,
    input  rv_core_pkg::reg_addr_t wb_addr,
    input  rv_core_pkg::word_t     wb_data,
    output rv_core_pkg::id_ex_t    id_ex
);

    rv_core_pkg::instr_t instr;
    rv_core_pkg::ctrl_t  ctrl;
    rv_core_pkg::word_t  imm;
    rv_core_pkg::word_t  rs1_data;
    rv_core_pkg::word_t  rs2_data;
    logic                legal;
    logic                issue;

    function automatic rv_core_pkg::alu_op_t alu_decode(input logic [2:0] funct3,
                                                        input logic       sub);
        case (funct3)
            rv_core_pkg::funct3_slt: return rv_core_pkg::alu_slt;
            rv_core_pkg::funct3_xor: return rv_core_pkg::alu_xor;
            rv_core_pkg::funct3_or:  return rv_core_pkg::alu_or;
            rv_core_pkg::funct3_and: return rv_core_pkg::alu_and;
            default:                 return sub ? rv_core_pkg::alu_sub : rv_core_pkg::alu_add;
        endcase
    endfunction

    assign instr = if_id.instr;

    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = rv_core_pkg::alu_add;
        imm         = '0;
        legal       = 1'b1;
        case (instr.r_fmt.opcode)
            rv_core_pkg::opcode_op: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = alu_decode(instr.r_fmt.funct3,
                                            instr.r_fmt.funct7 == rv_core_pkg::funct7_sub);
                legal          = instr.r_fmt.funct3 inside {3'b000, 3'b010, 3'b100,
                                                            3'b110, 3'b111};
            end
            rv_core_pkg::opcode_op_imm: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_op    = alu_decode(instr.i_fmt.funct3, 1'b0);
                imm            = {{20{instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
                legal          = instr.i_fmt.funct3 inside {3'b000, 3'b010, 3'b100,
                                                            3'b110, 3'b111};
            end
            rv_core_pkg::opcode_load: begin
                ctrl.reg_write  = 1'b1;
                ctrl.mem_read   = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                ctrl.alu_src    = 1'b1;
                imm             = {{20{instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
            end
            rv_core_pkg::opcode_store: begin
                ctrl.mem_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                imm            = {{20{instr.s_fmt.imm_hi[6]}}, instr.s_fmt.imm_hi,
                                  instr.s_fmt.imm_lo};
            end
            rv_core_pkg::opcode_branch: begin
                ctrl.branch = 1'b1;
                imm         = {{19{instr.b_fmt.imm_12}}, instr.b_fmt.imm_12,
                               instr.b_fmt.imm_11, instr.b_fmt.imm_10_5,
                               instr.b_fmt.imm_4_1, 1'b0};
                legal       = instr.b_fmt.funct3 == rv_core_pkg::funct3_beq ||
                              instr.b_fmt.funct3 == rv_core_pkg::funct3_bne;
            end
            default: legal = 1'b0;
        endcase
    end

    register_file u_regs (
        .clk      (clk),
        .arst_n   (arst_n),
        .rs1      (instr.r_fmt.rs1),
        .rs2      (instr.r_fmt.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr_en    (wb_en),
        .wr_addr  (wb_addr),
        .wr_data  (wb_data)
    );

    // Unsupported encodings, load-use stalls and branch flushes leave a bubble
    assign issue = if_id.valid && legal && !stall && !flush;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            id_ex.valid <= 1'b0;
            id_ex.ctrl  <= '0;
        end else begin
            id_ex.valid    <= issue;
            id_ex.ctrl     <= issue ? ctrl : '0;
            id_ex.pc       <= if_id.pc;
            id_ex.rs1_data <= rs1_data;
            id_ex.rs2_data <= rs2_data;
            id_ex.imm      <= imm;
            id_ex.rs1      <= instr.r_fmt.rs1;
            id_ex.rs2      <= instr.r_fmt.rs2;
            id_ex.rd       <= instr.r_fmt.rd;
            id_ex.funct3   <= instr.r_fmt.funct3;
        end
    end

endmodule

/* hw/hazard_unit.sv */
`timescale 1ns/1ps

module hazard_unit (
    input  rv_core_pkg::if_id_t   if_id,
    input  rv_core_pkg::id_ex_t   id_ex,
    input  rv_core_pkg::ex_mem_t  ex_mem,
    input  rv_core_pkg::mem_wb_t  mem_wb,
    output logic                  stall,
    output rv_core_pkg::fwd_sel_t fwd_a,
    output rv_core_pkg::fwd_sel_t fwd_b
);

    function automatic rv_core_pkg::fwd_sel_t fwd_select(input rv_core_pkg::reg_addr_t src);
        // Younger result in the memory stage has priority
        if (ex_mem.valid && ex_mem.ctrl.reg_write && ex_mem.rd != '0 && ex_mem.rd == src) begin
            return rv_core_pkg::fwd_mem;
        end
        if (mem_wb.valid && mem_wb.reg_write && mem_wb.rd != '0 && mem_wb.rd == src) begin
            return rv_core_pkg::fwd_wb;
        end
        return rv_core_pkg::fwd_none;
    endfunction

    // Load in execute feeding the instruction in decode
    always_comb begin
        stall = if_id.valid && id_ex.valid && id_ex.ctrl.mem_read && id_ex.rd != '0 &&
                (id_ex.rd == if_id.instr.r_fmt.rs1 || id_ex.rd == if_id.instr.r_fmt.rs2);
    end

    always_comb begin
        fwd_a = fwd_select(id_ex.rs1);
        fwd_b = fwd_select(id_ex.rs2);
    end

endmodule

/* hw/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage (
    input  logic                  clk,
    input  logic                  arst_n,
    input  rv_core_pkg::id_ex_t   id_ex,
    input  rv_core_pkg::fwd_sel_t fwd_a,
    input  rv_core_pkg::fwd_sel_t fwd_b,
    input  rv_core_pkg::word_t    wb_data,
    output logic                  branch_taken,
    output rv_core_pkg::word_t    branch_target,
    output rv_core_pkg::ex_mem_t  ex_mem
);

    rv_core_pkg::word_t op_a;
    rv_core_pkg::word_t rs2_value;
    rv_core_pkg::word_t op_b;
    rv_core_pkg::word_t alu_result;
    logic               equal;

    function automatic rv_core_pkg::word_t forward(input rv_core_pkg::fwd_sel_t sel,
                                                   input rv_core_pkg::word_t    reg_value);
        case (sel)
            rv_core_pkg::fwd_mem: return ex_mem.alu_result;
            rv_core_pkg::fwd_wb:  return wb_data;
            default:              return reg_value;
        endcase
    endfunction

    always_comb begin
        op_a      = forward(fwd_a, id_ex.rs1_data);
        rs2_value = forward(fwd_b, id_ex.rs2_data);
        op_b      = id_ex.ctrl.alu_src ? id_ex.imm : rs2_value;
    end

    always_comb begin
        case (id_ex.ctrl.alu_op)
            rv_core_pkg::alu_sub: alu_result = op_a - op_b;
            rv_core_pkg::alu_and: alu_result = op_a & op_b;
            rv_core_pkg::alu_or:  alu_result = op_a | op_b;
            rv_core_pkg::alu_xor: alu_result = op_a ^ op_b;
            rv_core_pkg::alu_slt: alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
            default:              alu_result = op_a + op_b;
        endcase
    end

    // BEQ and BNE both resolve on operand equality
    assign equal         = op_a == rs2_value;
    assign branch_taken  = id_ex.valid && id_ex.ctrl.branch &&
                           (id_ex.funct3 == rv_core_pkg::funct3_bne ? !equal : equal);
    assign branch_target = id_ex.pc + id_ex.imm;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_mem.valid <= 1'b0;
            ex_mem.ctrl  <= '0;
        end else begin
            ex_mem.valid      <= id_ex.valid;
            ex_mem.ctrl       <= id_ex.ctrl;
            ex_mem.alu_result <= alu_result;
            ex_mem.store_data <= rs2_value;
            ex_mem.rd         <= id_ex.rd;
        end
    end

endmodule

/* hw/data_memory.sv */
`timescale 1ns/1ps

module data_memory (
    input  logic                                clk,
    input  logic [rv_core_pkg::dmem_addr_bits-1:0] addr,
    input  logic                                wr_en,
    input  rv_core_pkg::word_t                  wr_data,
    output rv_core_pkg::word_t                  rd_data
);

    rv_core_pkg::word_t mem [rv_core_pkg::dmem_words];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[addr] <= wr_data;
        end
    end

    // Asynchronous read so a load completes inside its memory cycle
    assign rd_data = mem[addr];

endmodule

/* hw/memory_writeback.sv */
`timescale 1ns/1ps

module memory_writeback (
    input  logic                       clk,
    input  logic                       arst_n,
    input  rv_core_pkg::ex_mem_t       ex_mem,
    output rv_core_pkg::mem_wb_t       mem_wb,
    output rv_core_pkg::word_t         wb_data,
    output rv_core_pkg::wb_report_t    wb,
    output rv_core_pkg::store_report_t store
);

    rv_core_pkg::word_t load_data;

    // Word index comes from address bits five down to two
    data_memory u_dmem (
        .clk     (clk),
        .addr    (ex_mem.alu_result[rv_core_pkg::dmem_addr_bits+1:2]),
        .wr_en   (store.valid),
        .wr_data (ex_mem.store_data),
        .rd_data (load_data)
    );

    assign store.valid = ex_mem.valid && ex_mem.ctrl.mem_write;
    assign store.addr  = ex_mem.alu_result;
    assign store.data  = ex_mem.store_data;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_wb.valid      <= 1'b0;
            mem_wb.reg_write  <= 1'b0;
            mem_wb.mem_to_reg <= 1'b0;
        end else begin
            mem_wb.valid      <= ex_mem.valid;
            mem_wb.reg_write  <= ex_mem.valid && ex_mem.ctrl.reg_write;
            mem_wb.mem_to_reg <= ex_mem.ctrl.mem_to_reg;
            mem_wb.alu_result <= ex_mem.alu_result;
            mem_wb.load_data  <= load_data;
            mem_wb.rd         <= ex_mem.rd;
        end
    end

    assign wb_data  = mem_wb.mem_to_reg ? mem_wb.load_data : mem_wb.alu_result;

    // Writes to x0 are architecturally invisible
    assign wb.valid = mem_wb.valid && mem_wb.reg_write && mem_wb.rd != '0;
    assign wb.rd    = mem_wb.rd;
    assign wb.data  = wb_data;

endmodule

/* hw/pipeline_core.sv */
`timescale 1ns/1ps

module pipeline_core (
    input  logic                       clk,
    input  logic                       arst_n,
    output rv_core_pkg::word_t         imem_addr,
    input  rv_core_pkg::instr_t        imem_data,
    output rv_core_pkg::wb_report_t    wb,
    output rv_core_pkg::store_report_t store
);

    rv_core_pkg::if_id_t   if_id;
    rv_core_pkg::id_ex_t   id_ex;
    rv_core_pkg::ex_mem_t  ex_mem;
    rv_core_pkg::mem_wb_t  mem_wb;
    rv_core_pkg::fwd_sel_t fwd_a;
    rv_core_pkg::fwd_sel_t fwd_b;
    rv_core_pkg::word_t    branch_target;
    rv_core_pkg::word_t    wb_data;
    logic                  stall;
    logic                  branch_taken;

    fetch_stage u_fetch (
        .clk           (clk),
        .arst_n        (arst_n),
        .stall         (stall),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .imem_addr     (imem_addr),
        .imem_data     (imem_data),
        .if_id         (if_id)
    );

    // Register file write port sits on the MEM/WB register
    decode_stage u_decode (
        .clk     (clk),
        .arst_n  (arst_n),
        .if_id   (if_id),
        .stall   (stall),
        .flush   (branch_taken),
        .wb_en   (mem_wb.reg_write),
        .wb_addr (mem_wb.rd),
        .wb_data (wb_data),
        .id_ex   (id_ex)
    );

    hazard_unit u_hazard (
        .if_id  (if_id),
        .id_ex  (id_ex),
        .ex_mem (ex_mem),
        .mem_wb (mem_wb),
        .stall  (stall),
        .fwd_a  (fwd_a),
        .fwd_b  (fwd_b)
    );

    execute_stage u_execute (
        .clk           (clk),
        .arst_n        (arst_n),
        .id_ex         (id_ex),
        .fwd_a         (fwd_a),
        .fwd_b         (fwd_b),
        .wb_data       (wb_data),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .ex_mem        (ex_mem)
    );

    memory_writeback u_mem_wb (
        .clk     (clk),
        .arst_n  (arst_n),
        .ex_mem  (ex_mem),
        .mem_wb  (mem_wb),
        .wb_data (wb_data),
        .wb      (wb),
        .store   (store)
    );

endmodule

/* verification/core_checker.sv */
`timescale 1ns/1ps

module core_checker (
    input logic                       clk,
    input logic                       arst_n,
    input rv_core_pkg::wb_report_t    wb,
    input rv_core_pkg::store_report_t store
);

    // Report strobes stay quiet while reset is held
    reset_quiet: assert property (@(posedge clk) !arst_n |-> !wb.valid && !store.valid)
        else $error("report strobe raised while reset is asserted");

    wb_rd_nonzero: assert property (@(posedge clk) disable iff (!arst_n)
        wb.valid |-> wb.rd != 5'd0)
        else $error("writeback reported for register x0");

    // Data memory spans 16 words
    store_addr_legal: assert property (@(posedge clk) disable iff (!arst_n)
        store.valid |-> store.addr[1:0] == 2'b00 && store.addr < 32'd64)
        else $error("store address %08h is unaligned or outside data memory", store.addr);

endmodule

bind pipeline_core core_checker u_core_checker (
    .clk    (clk),
    .arst_n (arst_n),
    .wb     (wb),
    .store  (store)
);

/* verification/tb_pipeline_core.sv */
`timescale 1ns/1ps

module tb_pipeline_core;

    localparam int reset_cycles    = 10;
    localparam int drive_delay     = 1;
    localparam int rom_depth       = 128;
    localparam int clear_words     = 16;
    localparam int random_words    = 60;
    localparam int last_idx        = clear_words + random_words;
    localparam int drain_cycles    = 20;
    // Eight cycles per program word on top of reset
    localparam int watchdog_cycles = (last_idx + 1) * 8 + reset_cycles;

    logic                       clk;
    logic                       arst_n;
    rv_core_pkg::word_t         imem_addr;
    rv_core_pkg::instr_t        imem_data;
    rv_core_pkg::wb_report_t    wb;
    rv_core_pkg::store_report_t store;

    rv_core_pkg::instr_t        rom [rom_depth];
    rv_core_pkg::word_t         model_regs [32];
    rv_core_pkg::word_t         model_mem [16];
    rv_core_pkg::wb_report_t    wb_q [$];
    rv_core_pkg::store_report_t store_q [$];
    integer                     seed;

    pipeline_core u_dut (
        .clk       (clk),
        .arst_n    (arst_n),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .wb        (wb),
        .store     (store)
    );

    // Program ROM answers in the same cycle
    assign imem_data = rom[imem_addr[8:2]];

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic int rand_below(input int n);
        int r;
        r = $random(seed);
        return (r & 32'h7fff_ffff) % n;
    endfunction

    function automatic rv_core_pkg::instr_t alu_instr(input logic [6:0]             funct7,
                                                      input rv_core_pkg::reg_addr_t rs2,
                                                      input rv_core_pkg::reg_addr_t rs1,
                                                      input logic [2:0]             funct3,
                                                      input rv_core_pkg::reg_addr_t rd);
        rv_core_pkg::instr_t ins;
        ins.r_fmt.funct7 = funct7;
        ins.r_fmt.rs2    = rs2;
        ins.r_fmt.rs1    = rs1;
        ins.r_fmt.funct3 = funct3;
        ins.r_fmt.rd     = rd;
        ins.r_fmt.opcode = rv_core_pkg::opcode_op;
        return ins;
    endfunction

    function automatic rv_core_pkg::instr_t imm_instr(input logic [6:0]             opcode,
                                                      input logic [11:0]            imm,
                                                      input rv_core_pkg::reg_addr_t rs1,
                                                      input logic [2:0]             funct3,
                                                      input rv_core_pkg::reg_addr_t rd);
        rv_core_pkg::instr_t ins;
        ins.i_fmt.imm    = imm;
        ins.i_fmt.rs1    = rs1;
        ins.i_fmt.funct3 = funct3;
        ins.i_fmt.rd     = rd;
        ins.i_fmt.opcode = opcode;
        return ins;
    endfunction

    function automatic rv_core_pkg::instr_t store_instr(input logic [11:0]            imm,
                                                        input rv_core_pkg::reg_addr_t rs2,
                                                        input rv_core_pkg::reg_addr_t rs1);
        rv_core_pkg::instr_t ins;
        ins.s_fmt.imm_hi = imm[11:5];
        ins.s_fmt.rs2    = rs2;
        ins.s_fmt.rs1    = rs1;
        ins.s_fmt.funct3 = 3'b010;
        ins.s_fmt.imm_lo = imm[4:0];
        ins.s_fmt.opcode = rv_core_pkg::opcode_store;
        return ins;
    endfunction

    function automatic rv_core_pkg::instr_t branch_instr(input logic [2:0]             funct3,
                                                         input rv_core_pkg::reg_addr_t rs1,
                                                         input rv_core_pkg::reg_addr_t rs2,
                                                         input logic [12:0]            offset);
        rv_core_pkg::instr_t ins;
        ins.b_fmt.imm_12   = offset[12];
        ins.b_fmt.imm_10_5 = offset[10:5];
        ins.b_fmt.rs2      = rs2;
        ins.b_fmt.rs1      = rs1;
        ins.b_fmt.funct3   = funct3;
        ins.b_fmt.imm_4_1  = offset[4:1];
        ins.b_fmt.imm_11   = offset[11];
        ins.b_fmt.opcode   = rv_core_pkg::opcode_branch;
        return ins;
    endfunction

    function automatic rv_core_pkg::instr_t random_alu(input rv_core_pkg::reg_addr_t rd,
                                                       input rv_core_pkg::reg_addr_t rs1,
                                                       input rv_core_pkg::reg_addr_t rs2);
        case (rand_below(6))
            0: return alu_instr(7'b0, rs2, rs1, rv_core_pkg::funct3_add_sub, rd);
            1: return alu_instr(rv_core_pkg::funct7_sub, rs2, rs1,
                                rv_core_pkg::funct3_add_sub, rd);
            2: return alu_instr(7'b0, rs2, rs1, rv_core_pkg::funct3_slt, rd);
            3: return alu_instr(7'b0, rs2, rs1, rv_core_pkg::funct3_xor, rd);
            4: return alu_instr(7'b0, rs2, rs1, rv_core_pkg::funct3_or, rd);
            default: return alu_instr(7'b0, rs2, rs1, rv_core_pkg::funct3_and, rd);
        endcase
    endfunction

    // Clear data memory, then random code on x0..x7, then a self-loop
    task automatic generate_program();
        int                     off;
        rv_core_pkg::reg_addr_t rd;
        rv_core_pkg::reg_addr_t rs1;
        rv_core_pkg::reg_addr_t rs2;
        for (int i = 0; i < rom_depth; i++) begin
            rom[i] = '0;
        end
        for (int w = 0; w < clear_words; w++) begin
            rom[w] = store_instr(12'(w * 4), 5'd0, 5'd0);
        end
        for (int idx = clear_words; idx < last_idx; idx++) begin
            rd  = rv_core_pkg::reg_addr_t'(rand_below(8));
            rs1 = rv_core_pkg::reg_addr_t'(rand_below(8));
            rs2 = rv_core_pkg::reg_addr_t'(rand_below(8));
            case (rand_below(10))
                0, 1, 2: rom[idx] = random_alu(rd, rs1, rs2);
                3, 4: rom[idx] = imm_instr(rv_core_pkg::opcode_op_imm, 12'(rand_below(4096)),
                                           rs1, 3'b000, rd);
                5, 6: rom[idx] = imm_instr(rv_core_pkg::opcode_load, 12'(rand_below(16) * 4),
                                           5'd0, 3'b010, rd);
                7: rom[idx] = store_instr(12'(rand_below(16) * 4), rs2, 5'd0);
                default: begin
                    off = 2 + rand_below(3);
                    // Never jump past the final loop
                    if (idx + off > last_idx) begin
                        off = last_idx - idx;
                    end
                    rom[idx] = branch_instr(rand_below(2) == 0 ? rv_core_pkg::funct3_beq :
                                            rv_core_pkg::funct3_bne, rs1, rs2, 13'(off * 4));
                end
            endcase
        end
        rom[last_idx] = branch_instr(rv_core_pkg::funct3_beq, 5'd0, 5'd0, 13'd0);
    endtask

    function automatic rv_core_pkg::word_t sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    task automatic retire_write(input rv_core_pkg::reg_addr_t rd, input rv_core_pkg::word_t value);
        rv_core_pkg::wb_report_t exp;
        if (rd != 5'd0) begin
            model_regs[rd] = value;
            exp.valid = 1'b1;
            exp.rd    = rd;
            exp.data  = value;
            wb_q.push_back(exp);
        end
    endtask

    // ISA-level execution up to the closing self-loop
    task automatic run_reference_model();
        rv_core_pkg::word_t         pc;
        rv_core_pkg::word_t         next_pc;
        rv_core_pkg::word_t         a;
        rv_core_pkg::word_t         b;
        rv_core_pkg::word_t         res;
        rv_core_pkg::word_t         addr;
        rv_core_pkg::instr_t        ins;
        rv_core_pkg::store_report_t st;
        logic [12:0]                boff;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < 16; i++) begin
            model_mem[i] = '0;
        end
        pc = '0;
        while (pc[8:2] != 7'(last_idx)) begin
            ins     = rom[pc[8:2]];
            a       = model_regs[ins.r_fmt.rs1];
            b       = model_regs[ins.r_fmt.rs2];
            next_pc = pc + 32'd4;
            case (ins.r_fmt.opcode)
                rv_core_pkg::opcode_op: begin
                    case (ins.r_fmt.funct3)
                        rv_core_pkg::funct3_slt: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        rv_core_pkg::funct3_xor: res = a ^ b;
                        rv_core_pkg::funct3_or:  res = a | b;
                        rv_core_pkg::funct3_and: res = a & b;
                        default: begin
                            res = (ins.r_fmt.funct7 == rv_core_pkg::funct7_sub) ? a - b : a + b;
                        end
                    endcase
                    retire_write(ins.r_fmt.rd, res);
                end
                rv_core_pkg::opcode_op_imm: retire_write(ins.i_fmt.rd, a + sext12(ins.i_fmt.imm));
                rv_core_pkg::opcode_load: begin
                    addr = a + sext12(ins.i_fmt.imm);
                    retire_write(ins.i_fmt.rd, model_mem[addr[5:2]]);
                end
                rv_core_pkg::opcode_store: begin
                    addr = a + sext12({ins.s_fmt.imm_hi, ins.s_fmt.imm_lo});
                    model_mem[addr[5:2]] = b;
                    st.valid = 1'b1;
                    st.addr  = addr;
                    st.data  = b;
                    store_q.push_back(st);
                end
                default: begin
                    boff = {ins.b_fmt.imm_12, ins.b_fmt.imm_11, ins.b_fmt.imm_10_5,
                            ins.b_fmt.imm_4_1, 1'b0};
                    if ((ins.b_fmt.funct3 == rv_core_pkg::funct3_beq) == (a == b)) begin
                        next_pc = pc + {{19{boff[12]}}, boff};
                    end
                end
            endcase
            pc = next_pc;
        end
    endtask

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic compare_wb(input rv_core_pkg::wb_report_t actual,
                              input rv_core_pkg::wb_report_t expected);
        if (actual.rd !== expected.rd || actual.data !== expected.data) begin
            stop_on_error($sformatf("ERROR at time %0t: writeback x%0d=%08h, expected x%0d=%08h",
                                    $time, actual.rd, actual.data, expected.rd, expected.data));
        end
    endtask

    task automatic compare_store(input rv_core_pkg::store_report_t actual,
                                 input rv_core_pkg::store_report_t expected);
        if (actual.addr !== expected.addr || actual.data !== expected.data) begin
            stop_on_error($sformatf("ERROR at time %0t: store [%08h]=%08h, expected [%08h]=%08h",
                                    $time, actual.addr, actual.data, expected.addr, expected.data));
        end
    endtask

    task automatic sample_reports();
        rv_core_pkg::wb_report_t    exp_wb;
        rv_core_pkg::store_report_t exp_store;
        if (wb.valid) begin
            if (wb_q.size() == 0) begin
                stop_on_error($sformatf("ERROR at time %0t: unexpected writeback to x%0d",
                                        $time, wb.rd));
            end else begin
                exp_wb = wb_q.pop_front();
                compare_wb(wb, exp_wb);
            end
        end
        if (store.valid) begin
            if (store_q.size() == 0) begin
                stop_on_error($sformatf("ERROR at time %0t: unexpected store to %08h",
                                        $time, store.addr));
            end else begin
                exp_store = store_q.pop_front();
                compare_store(store, exp_store);
            end
        end
    endtask

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        stop_on_error($sformatf("Watchdog expired at %0t: the core stopped producing results, %s",
                                $time, $sformatf("%0d writebacks and %0d stores never arrived",
                                                 wb_q.size(), store_q.size())));
    end

    initial begin
        arst_n = 1'b0;
        seed   = 5192;
        generate_program();
        run_reference_model();
        $display("Program ready: %0d writebacks and %0d stores expected",
                 wb_q.size(), store_q.size());
        repeat (reset_cycles) @(posedge clk);
        #(drive_delay);
        arst_n = 1'b1;
        // Reports are stable at the falling edge
        while (wb_q.size() != 0 || store_q.size() != 0) begin
            @(negedge clk);
            sample_reports();
        end
        // The closing self-loop must stay silent
        repeat (drain_cycles) begin
            @(negedge clk);
            sample_reports();
        end
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

/* tb.f */
hw/rv_core_pkg.sv
hw/fetch_stage.sv
hw/register_file.sv
hw/decode_stage.sv
hw/hazard_unit.sv
hw/execute_stage.sv
hw/data_memory.sv
hw/memory_writeback.sv
hw/pipeline_core.sv
verification/core_checker.sv
verification/tb_pipeline_core.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
    --top-module tb_pipeline_core \
    -f tb.f \
    -o sim_tb

# The log decides the verdict, so a failing run must not stop the script here
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation finished: PASS" sim.log; then
    echo "Result: pass"
    exit 0
fi
echo "Result: fail"
exit 1
